// File: sim.f
+incdir+testbench
rtl/rv_pkg.sv
rtl/exec_ctrl_if.sv
rtl/fetch_unit.sv
rtl/register_bank.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/data_memory.sv
rtl/monitor_port.sv
rtl/rv_step_core.sv
testbench/tb_rv_step_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f sim.f --top-module tb_rv_step_core -o tb_rv_step_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_rv_step_core > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

// File: testbench/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// ISA-level model state, word pc wraps at 64
word_t      m_regs [REG_COUNT];
word_t      m_mem  [DMEM_WORDS];
logic [5:0] m_pc;

function automatic void clear_model();
  for (int i = 0; i < REG_COUNT; i++) begin
    m_regs[i] = '0;
    m_mem[i]  = '0;
  end
  m_pc = '0;
endfunction

// alt picks sub or sra
function automatic word_t alu_calc(input logic [2:0] f3, input logic alt,
                                   input word_t a, input word_t b);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3:    return (a < b) ? 32'd1 : 32'd0;
    3'd4:    return a ^ b;
    3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic [31:0] gen_inst();
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  logic [11:0] imm;
  logic [12:0] boff;
  logic [6:0]  f7;
  int          kind;
  rd   = 5'($urandom);
  rs1  = 5'($urandom);
  rs2  = 5'($urandom);
  f3   = 3'($urandom);
  imm  = 12'($urandom);
  kind = $urandom_range(0, 9);
  f7   = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
  if (kind < 3) begin
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  end else if (kind < 6) begin
    if (f3 == 3'd1 || f3 == 3'd5) begin
      imm[11:5] = f3 == 3'd5 ? f7 : 7'h00;
    end
    return {imm, rs1, f3, rd, 7'b0010011};
  end else if (kind < 8) begin
    // word aligned offset, from x0 or from a register
    if ($urandom_range(0, 1) == 1) begin
      rs1 = '0;
      imm = 12'($urandom_range(0, 31) * 4);
    end else begin
      imm = 12'(($urandom_range(0, 15) - 8) * 4);
    end
    if (kind == 6) begin
      return {imm, rs1, 3'b010, rd, 7'b0000011};
    end
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  end
  f3 = 3'($urandom_range(0, 5));
  if (f3 > 3'd1) begin
    f3 = f3 + 3'd2;
  end
  boff = 13'($urandom_range(1, 6) * 4);
  if ($urandom_range(0, 1) == 1) begin
    boff = -boff;
  end
  return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
endfunction

function automatic void model_step(input logic [31:0] inst);
  word_t      a;
  word_t      b;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      addr;
  word_t      res;
  logic [2:0] f3;
  logic       wr;
  logic       take;
  a     = m_regs[inst[19:15]];
  b     = m_regs[inst[24:20]];
  f3    = inst[14:12];
  imm_i = 32'($signed(inst[31:20]));
  imm_s = 32'($signed({inst[31:25], inst[11:7]}));
  imm_b = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
  wr    = 1'b0;
  take  = 1'b0;
  res   = '0;
  case (inst[6:0])
    7'b0110011: begin
      wr  = 1'b1;
      res = alu_calc(f3, inst[30], a, b);
    end
    7'b0010011: begin
      wr  = 1'b1;
      res = alu_calc(f3, inst[30] && f3 == 3'd5, a, imm_i);
    end
    7'b0000011: begin
      wr   = 1'b1;
      addr = a + imm_i;
      res  = m_mem[addr[6:2]];
    end
    7'b0100011: begin
      addr = a + imm_s;
      m_mem[addr[6:2]] = b;
    end
    default: begin
      case (f3)
        3'd0:    take = a == b;
        3'd1:    take = a != b;
        3'd4:    take = $signed(a) < $signed(b);
        3'd5:    take = $signed(a) >= $signed(b);
        3'd6:    take = a < b;
        default: take = a >= b;
      endcase
    end
  endcase
  if (wr && inst[11:7] != 5'd0) begin
    m_regs[inst[11:7]] = res;
  end
  // byte offset over 4, modulo the 64 word program space
  m_pc = take ? m_pc + imm_b[7:2] : m_pc + 6'd1;
endfunction

`endif

// File: testbench/tb_rv_step_core.sv
`timescale 1ns/10ps

module tb_rv_step_core import rv_pkg::*; ();

  localparam int NUM_STEPS   = 300;
  localparam int READ_EVERY  = 25;
  localparam int READ_CYCLES = (NUM_STEPS / READ_EVERY + 2) * 32 * 8;
  localparam int WATCH_CYCLES = NUM_STEPS * 20 + READ_CYCLES + 100;

  logic       clk = 1'b0;
  logic       rst;
  logic       step;
  imem_addr_t imem_addr;
  word_t      imem_data;
  logic       wb_cyc;
  logic       wb_stb;
  mon_addr_t  wb_adr;
  word_t      wb_dat;
  logic       wb_ack;

  logic [31:0] prog [IMEM_WORDS];

  `include "rv_ref_model.svh"

  rv_step_core u_dut (
    .clk       (clk),
    .rst       (rst),
    .step      (step),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .wb_dat    (wb_dat),
    .wb_ack    (wb_ack)
  );

  always #4 clk = ~clk;

  task automatic check_value(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic do_step();
    @(negedge clk);
    check_value("fetch address", 32'(imem_addr), 32'(m_pc));
    imem_data = prog[imem_addr];
    step      = 1'b1;
    model_step(prog[m_pc]);
    @(negedge clk);
    step = 1'b0;
    check_value("pc after step", 32'(imem_addr), 32'(m_pc));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
    check_value("pc while idle", 32'(imem_addr), 32'(m_pc));
  endtask

  // ack due one cycle after the strobe is first sampled
  task automatic wb_read(input mon_addr_t addr, output word_t data);
    int waited;
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_adr = addr;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && waited < 8);
    check_value("ack latency", 32'(waited), 32'd1);
    data = wb_dat;
    // strobe still up for the cycle after the ack
    @(negedge clk);
    check_value("ack length", 32'(wb_ack), 32'd0);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic read_all_regs();
    word_t data;
    for (int r = 0; r < REG_COUNT; r++) begin
      wb_read(mon_addr_t'(r), data);
      check_value($sformatf("register x%0d", r), data, m_regs[r]);
    end
  endtask

  task automatic read_all_mem();
    word_t data;
    for (int w = 0; w < DMEM_WORDS; w++) begin
      wb_read(mon_addr_t'(REG_COUNT + w), data);
      check_value($sformatf("memory word %0d", w), data, m_mem[w]);
    end
  endtask

  initial begin
    repeat (WATCH_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCH_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(32'h2bc133e6));
    rst       = 1'b1;
    step      = 1'b0;
    imem_data = '0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_adr    = '0;
    clear_model();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      prog[i] = gen_inst();
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;
    check_value("pc after reset", 32'(imem_addr), 32'd0);
    check_value("ack after reset", 32'(wb_ack), 32'd0);
    read_all_regs();

    for (int s = 1; s <= NUM_STEPS; s++) begin
      do_step();
      if (s % READ_EVERY == 0) begin
        idle_cycles(3);
        read_all_regs();
        idle_cycles(1);
      end
    end
    read_all_mem();
    idle_cycles(2);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: rtl/rv_step_core.sv
`timescale 1ns/10ps

module rv_step_core import rv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       step,
  output imem_addr_t imem_addr,
  input  word_t      imem_data,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  mon_addr_t  wb_adr,
  output word_t      wb_dat,
  output logic       wb_ack
);

  word_t      alu_result;
  word_t      load_data;
  word_t      imm_out;
  logic       take_branch;
  reg_addr_t  mon_reg_addr;
  dmem_addr_t mon_mem_addr;
  word_t      mon_reg_data;
  word_t      mon_mem_data;

  exec_ctrl_if ctrl ();

  fetch_unit u_fetch (
    .clk           (clk),
    .rst           (rst),
    .step          (step),
    .take_branch   (take_branch),
    .branch_offset (imm_out),
    .pc            (imem_addr)
  );

  decode_unit u_decode (
    .clk          (clk),
    .step         (step),
    .inst         (imem_data),
    .alu_result   (alu_result),
    .load_data    (load_data),
    .mon_addr     (mon_reg_addr),
    .mon_reg_data (mon_reg_data),
    .ctrl         (ctrl.decode),
    .imm_out      (imm_out)
  );

  execute_unit u_execute (
    .ctrl        (ctrl.execute),
    .alu_result  (alu_result),
    .take_branch (take_branch)
  );

  data_memory u_dmem (
    .clk        (clk),
    .step       (step),
    .ctrl       (ctrl.memory),
    .alu_result (alu_result),
    .load_data  (load_data),
    .mon_addr   (mon_mem_addr),
    .mon_data   (mon_mem_data)
  );

  monitor_port u_monitor (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_adr   (wb_adr),
    .reg_data (mon_reg_data),
    .mem_data (mon_mem_data),
    .reg_addr (mon_reg_addr),
    .mem_addr (mon_mem_addr),
    .wb_dat   (wb_dat),
    .wb_ack   (wb_ack)
  );

endmodule

// File: rtl/monitor_port.sv
`timescale 1ns/10ps

module monitor_port import rv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  mon_addr_t  wb_adr,
  input  word_t      reg_data,
  input  word_t      mem_data,
  output reg_addr_t  reg_addr,
  output dmem_addr_t mem_addr,
  output word_t      wb_dat,
  output logic       wb_ack
);

  logic sel_mem;

  assign sel_mem  = wb_adr[MON_AW-1];
  assign reg_addr = wb_adr[REG_AW-1:0];
  assign mem_addr = wb_adr[DMEM_AW-1:0];

  // single ack per strobe, cleared while the master drops stb
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_cyc && wb_stb && !wb_ack;
    end
  end

  always_ff @(posedge clk) begin
    wb_dat <= sel_mem ? mem_data : reg_data;
  end

endmodule

// File: rtl/data_memory.sv
`timescale 1ns/10ps

module data_memory import rv_pkg::*; (
  input  logic         clk,
  input  logic         step,
  exec_ctrl_if.memory  ctrl,
  input  word_t        alu_result,
  output word_t        load_data,
  input  dmem_addr_t   mon_addr,
  output word_t        mon_data
);

  word_t      mem [DMEM_WORDS];
  dmem_addr_t word_idx;

  initial begin
    for (int i = 0; i < DMEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // byte address to word index
  assign word_idx = alu_result[DMEM_AW+1:2];

  always_ff @(posedge clk) begin
    if (step && ctrl.mem_write) begin
      mem[word_idx] <= ctrl.rs2_data;
    end
  end

  assign load_data = ctrl.mem_read ? mem[word_idx] : '0;
  assign mon_data  = mem[mon_addr];

endmodule

// File: rtl/execute_unit.sv
`timescale 1ns/10ps

module execute_unit import rv_pkg::*; (
  exec_ctrl_if.execute ctrl,
  output word_t        alu_result,
  output logic         take_branch
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;

  assign op_a  = ctrl.rs1_data;
  assign op_b  = ctrl.alu_src ? ctrl.imm : ctrl.rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_sel)
      ALU_ADD:  alu_result = op_a + op_b;
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_SLL:  alu_result = op_a << shamt;
      ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result = {31'b0, op_a < op_b};
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SRL:  alu_result = op_a >> shamt;
      ALU_SRA:  alu_result = word_t'($signed(op_a) >>> shamt);
      ALU_OR:   alu_result = op_a | op_b;
      ALU_AND:  alu_result = op_a & op_b;
      default:  alu_result = '0;
    endcase
  end

  // branches always compare the two register operands
  assign equal       = ctrl.rs1_data == ctrl.rs2_data;
  assign lt_signed   = $signed(ctrl.rs1_data) < $signed(ctrl.rs2_data);
  assign lt_unsigned = ctrl.rs1_data < ctrl.rs2_data;

  always_comb begin
    take_branch = 1'b0;
    if (ctrl.is_branch) begin
      case (ctrl.funct3)
        3'b000:  take_branch = equal;
        3'b001:  take_branch = !equal;
        3'b100:  take_branch = lt_signed;
        3'b101:  take_branch = !lt_signed;
        3'b110:  take_branch = lt_unsigned;
        3'b111:  take_branch = !lt_unsigned;
        default: take_branch = 1'b0;
      endcase
    end
  end

endmodule

// File: rtl/decode_unit.sv
`timescale 1ns/10ps

module decode_unit import rv_pkg::*; (
  input  logic               clk,
  input  logic               step,
  input  word_t              inst,
  input  word_t              alu_result,
  input  word_t              load_data,
  input  reg_addr_t          mon_addr,
  output word_t              mon_reg_data,
  exec_ctrl_if.decode        ctrl,
  output word_t              imm_out
);

  opcode_e   opcode;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  logic      reg_write;
  word_t     imm;
  word_t     write_data;

  assign opcode      = opcode_e'(inst[6:0]);
  assign rd          = inst[11:7];
  assign rs1         = inst[19:15];
  assign rs2         = inst[24:20];
  assign ctrl.funct3 = inst[14:12];

  always_comb begin
    imm            = '0;
    reg_write      = 1'b0;
    ctrl.alu_sel   = ALU_ADD;
    ctrl.alu_src   = 1'b0;
    ctrl.is_branch = 1'b0;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    case (opcode)
      OP_REG: begin
        reg_write    = 1'b1;
        ctrl.alu_sel = alu_map(inst[14:12], inst[30], 1'b1);
      end
      OP_IMM: begin
        reg_write    = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.alu_sel = alu_map(inst[14:12], inst[30], 1'b0);
        imm          = {{20{inst[31]}}, inst[31:20]};
      end
      OP_LOAD: begin
        reg_write     = 1'b1;
        ctrl.alu_src  = 1'b1;
        ctrl.mem_read = 1'b1;
        imm           = {{20{inst[31]}}, inst[31:20]};
      end
      OP_STORE: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
        imm            = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      OP_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.alu_sel   = ALU_SUB;
        imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      default: begin
        // unsupported opcodes leave state untouched
        reg_write = 1'b0;
      end
    endcase
  end

  assign ctrl.imm   = imm;
  assign imm_out    = imm;
  assign write_data = ctrl.mem_read ? load_data : alu_result;

  // alt is instruction bit 30, sub only exists for register ops
  function automatic alu_sel_e alu_map(input logic [2:0] f3, input logic alt,
                                       input logic is_reg);
    case (f3)
      3'd0:    alu_map = (is_reg && alt) ? ALU_SUB : ALU_ADD;
      3'd1:    alu_map = ALU_SLL;
      3'd2:    alu_map = ALU_SLT;
      3'd3:    alu_map = ALU_SLTU;
      3'd4:    alu_map = ALU_XOR;
      3'd5:    alu_map = alt ? ALU_SRA : ALU_SRL;
      3'd6:    alu_map = ALU_OR;
      default: alu_map = ALU_AND;
    endcase
  endfunction

  register_bank u_regs (
    .clk        (clk),
    .write_en   (step && reg_write),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .mon_addr   (mon_addr),
    .write_data (write_data),
    .rs1_data   (ctrl.rs1_data),
    .rs2_data   (ctrl.rs2_data),
    .mon_data   (mon_reg_data)
  );

endmodule

// File: rtl/register_bank.sv
`timescale 1ns/10ps

module register_bank import rv_pkg::*; (
  input  logic      clk,
  input  logic      write_en,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  reg_addr_t mon_addr,
  input  word_t     write_data,
  output word_t     rs1_data,
  output word_t     rs2_data,
  output word_t     mon_data
);

  word_t regs [REG_COUNT];

  initial begin
    for (int i = 0; i < REG_COUNT; i++) begin
      regs[i] = '0;
    end
  end

  // x0 never written so it stays zero
  always_ff @(posedge clk) begin
    if (write_en && rd != '0) begin
      regs[rd] <= write_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];
  assign mon_data = regs[mon_addr];

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit import rv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       step,
  input  logic       take_branch,
  input  word_t      branch_offset,
  output imem_addr_t pc
);

  imem_addr_t pc_inc;

  // byte offset to word offset, wraps with the pc
  assign pc_inc = take_branch ? imem_addr_t'(branch_offset[IMEM_AW+1:2])
                              : imem_addr_t'(1);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (step) begin
      pc <= pc + pc_inc;
    end
  end

endmodule

// File: rtl/exec_ctrl_if.sv
`timescale 1ns/10ps

interface exec_ctrl_if import rv_pkg::*; ();

  word_t       rs1_data;
  word_t       rs2_data;
  word_t       imm;
  alu_sel_e    alu_sel;
  logic        alu_src;
  logic        is_branch;
  logic [2:0]  funct3;
  logic        mem_read;
  logic        mem_write;

  modport decode (
    output rs1_data, rs2_data, imm, alu_sel, alu_src, is_branch, funct3,
    output mem_read, mem_write
  );

  modport execute (
    input rs1_data, rs2_data, imm, alu_sel, alu_src, is_branch, funct3
  );

  modport memory (
    input rs2_data, mem_read, mem_write
  );

endinterface

// File: rtl/rv_pkg.sv
package rv_pkg;

  localparam int REG_COUNT  = 32;
  localparam int DMEM_WORDS = 32;
  localparam int IMEM_WORDS = 64;

  localparam int REG_AW  = $clog2(REG_COUNT);
  localparam int DMEM_AW = $clog2(DMEM_WORDS);
  localparam int IMEM_AW = $clog2(IMEM_WORDS);
  // upper half of the monitor space maps to data memory
  localparam int MON_AW  = REG_AW + 1;

  typedef logic [31:0]         word_t;
  typedef logic [REG_AW-1:0]   reg_addr_t;
  typedef logic [IMEM_AW-1:0]  imem_addr_t;
  typedef logic [DMEM_AW-1:0]  dmem_addr_t;
  typedef logic [MON_AW-1:0]   mon_addr_t;

  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_sel_e;

endpackage
